// File: common/mshr_cfg_pkg.sv
package mshr_cfg_pkg;

    // MSHR geometry
    localparam int unsigned MSHR_SETS  = 4;
    localparam int unsigned MSHR_WAYS  = 2;
    localparam int unsigned MSHR_SLOTS = MSHR_SETS * MSHR_WAYS;
    localparam int unsigned MSHR_SET_W = $clog2(MSHR_SETS);
    localparam int unsigned MSHR_WAY_W = $clog2(MSHR_WAYS);

    // Cache line addressing
    localparam int unsigned CACHE_SET_W = 6;
    localparam int unsigned TAG_W       = 8;
    localparam int unsigned NLINE_W     = TAG_W + CACHE_SET_W;

    // Request fields kept per entry
    localparam int unsigned REQ_ID_W    = 4;
    localparam int unsigned SRC_ID_W    = 2;
    localparam int unsigned WORD_W      = 3;
    localparam int unsigned CACHE_WAY_W = 2;

    typedef logic [MSHR_SET_W-1:0]  mshr_set_t;
    typedef logic [MSHR_WAY_W-1:0]  mshr_way_t;
    typedef logic [CACHE_SET_W-1:0] cache_set_t;
    typedef logic [TAG_W-1:0]       tag_t;

    // Line number is the tag above the cache set
    typedef logic [NLINE_W-1:0]     nline_t;

endpackage

// File: common/mshr_entry_pkg.sv
package mshr_entry_pkg;

    // One outstanding refill as stored in the entry memory
    typedef struct packed {
        mshr_cfg_pkg::tag_t                         tag;
        logic [mshr_cfg_pkg::REQ_ID_W-1:0]          req_id;
        logic [mshr_cfg_pkg::SRC_ID_W-1:0]          src_id;
        logic [mshr_cfg_pkg::WORD_W-1:0]            word_idx;
        logic [mshr_cfg_pkg::CACHE_WAY_W-1:0]       victim_way;
        logic                                       need_rsp;
    } mshr_entry_t;

    // Operation seen by the entry memory in a cycle
    // Ack has priority, then alloc, then check
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,
        OP_CHECK = 2'd1,
        OP_ALLOC = 2'd2,
        OP_ACK   = 2'd3
    } mshr_op_e;

endpackage

// File: mshr/mshr_valid_table.sv
`timescale 1ns/1ps

module mshr_valid_table (
    input  logic                                                      clk_i,
    input  logic                                                      rst_ni,

    input  logic                                                      alloc_i,
    input  mshr_cfg_pkg::nline_t                                      alloc_nline_i,

    input  logic                                                      ack_i,
    input  mshr_cfg_pkg::mshr_set_t                                   ack_set_i,
    input  mshr_cfg_pkg::mshr_way_t                                   ack_way_i,

    input  mshr_cfg_pkg::mshr_set_t                                   check_set_q_i,

    output mshr_cfg_pkg::mshr_way_t                                   alloc_way_o,
    output logic                                                      alloc_full_o,
    output logic                                                      empty_o,
    output logic                                                      full_o,

    output logic [mshr_cfg_pkg::MSHR_SLOTS-1:0]                       valid_o,
    output mshr_cfg_pkg::cache_set_t [mshr_cfg_pkg::MSHR_SLOTS-1:0]   cache_set_o
);

    logic [mshr_cfg_pkg::MSHR_SLOTS-1:0]                      valid_q;
    mshr_cfg_pkg::cache_set_t [mshr_cfg_pkg::MSHR_SLOTS-1:0]  cache_set_q;

    mshr_entry_pkg::mshr_op_e                                 op;
    mshr_cfg_pkg::mshr_set_t                                  alloc_set;
    logic [mshr_cfg_pkg::MSHR_WAY_W+mshr_cfg_pkg::MSHR_SET_W-1:0] slot;

    // MSHR set is the low bits of the cache set
    assign alloc_set = alloc_nline_i[mshr_cfg_pkg::MSHR_SET_W-1:0];

    // Lowest free way in the allocation set
    always_comb begin
        alloc_way_o = '0;
        for (int w = mshr_cfg_pkg::MSHR_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[w * mshr_cfg_pkg::MSHR_SETS + int'(alloc_set)]) begin
                alloc_way_o = mshr_cfg_pkg::mshr_way_t'(w);
            end
        end
    end

    // No free way left in the set under check in stage 1
    always_comb begin
        alloc_full_o = 1'b1;
        for (int w = 0; w < mshr_cfg_pkg::MSHR_WAYS; w++) begin
            if (!valid_q[w * mshr_cfg_pkg::MSHR_SETS + int'(check_set_q_i)]) begin
                alloc_full_o = 1'b0;
            end
        end
    end

    assign empty_o = ~|valid_q;
    assign full_o  = &valid_q;

    // Checks leave the table untouched
    always_comb begin
        if (ack_i) begin
            op = mshr_entry_pkg::OP_ACK;
        end else if (alloc_i) begin
            op = mshr_entry_pkg::OP_ALLOC;
        end else begin
            op = mshr_entry_pkg::OP_IDLE;
        end
    end

    // Slot index is way above set
    always_comb begin
        case (op)
            mshr_entry_pkg::OP_ACK:   slot = {ack_way_i, ack_set_i};
            mshr_entry_pkg::OP_ALLOC: slot = {alloc_way_o, alloc_set};
            default:                  slot = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            case (op)
                mshr_entry_pkg::OP_ALLOC: valid_q[slot] <= 1'b1;
                mshr_entry_pkg::OP_ACK:   valid_q[slot] <= 1'b0;
                default: ;
            endcase
        end
    end

    // Cache set of each pending line for hit and ack readout
    always_ff @(posedge clk_i) begin
        if (op == mshr_entry_pkg::OP_ALLOC) begin
            cache_set_q[slot] <= alloc_nline_i[mshr_cfg_pkg::CACHE_SET_W-1:0];
        end
    end

    assign valid_o     = valid_q;
    assign cache_set_o = cache_set_q;

endmodule

// File: mshr/mshr_entry_ram.sv
`timescale 1ns/1ps

module mshr_entry_ram (
    input  logic                                                        clk_i,
    input  logic                                                        rst_ni,

    input  logic                                                        check_i,
    input  logic                                                        alloc_i,
    input  logic                                                        ack_i,

    input  mshr_cfg_pkg::cache_set_t                                    check_set_i,
    input  mshr_cfg_pkg::mshr_set_t                                     ack_set_i,

    input  mshr_cfg_pkg::nline_t                                        alloc_nline_i,
    input  mshr_cfg_pkg::mshr_way_t                                     alloc_way_i,
    input  logic [mshr_cfg_pkg::REQ_ID_W-1:0]                           alloc_req_id_i,
    input  logic [mshr_cfg_pkg::SRC_ID_W-1:0]                           alloc_src_id_i,
    input  logic [mshr_cfg_pkg::WORD_W-1:0]                             alloc_word_i,
    input  logic [mshr_cfg_pkg::CACHE_WAY_W-1:0]                        alloc_victim_way_i,
    input  logic                                                        alloc_need_rsp_i,

    output mshr_entry_pkg::mshr_entry_t [mshr_cfg_pkg::MSHR_WAYS-1:0]   rentry_o
);

    mshr_entry_pkg::mshr_entry_t mem_q [mshr_cfg_pkg::MSHR_SETS-1:0][mshr_cfg_pkg::MSHR_WAYS-1:0];
    mshr_entry_pkg::mshr_entry_t [mshr_cfg_pkg::MSHR_WAYS-1:0] rentry_q;

    mshr_entry_pkg::mshr_op_e    op;
    mshr_cfg_pkg::mshr_set_t     addr;
    mshr_entry_pkg::mshr_entry_t wentry;

    always_comb begin
        if (ack_i) begin
            op = mshr_entry_pkg::OP_ACK;
        end else if (alloc_i) begin
            op = mshr_entry_pkg::OP_ALLOC;
        end else if (check_i) begin
            op = mshr_entry_pkg::OP_CHECK;
        end else begin
            op = mshr_entry_pkg::OP_IDLE;
        end
    end

    always_comb begin
        case (op)
            mshr_entry_pkg::OP_ACK:   addr = ack_set_i;
            mshr_entry_pkg::OP_ALLOC: addr = alloc_nline_i[mshr_cfg_pkg::MSHR_SET_W-1:0];
            mshr_entry_pkg::OP_CHECK: addr = check_set_i[mshr_cfg_pkg::MSHR_SET_W-1:0];
            default:                  addr = '0;
        endcase
    end

    // Tag sits above the cache set in the line number
    always_comb begin
        wentry.tag        = alloc_nline_i[mshr_cfg_pkg::NLINE_W-1:mshr_cfg_pkg::CACHE_SET_W];
        wentry.req_id     = alloc_req_id_i;
        wentry.src_id     = alloc_src_id_i;
        wentry.word_idx   = alloc_word_i;
        wentry.victim_way = alloc_victim_way_i;
        wentry.need_rsp   = alloc_need_rsp_i;
    end

    // Only the chosen way is written
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < mshr_cfg_pkg::MSHR_WAYS; w++) begin
            if (op == mshr_entry_pkg::OP_ALLOC && int'(alloc_way_i) == w) begin
                mem_q[addr][w] <= wentry;
            end
        end
    end

    // All ways read together and held until the next read
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rentry_q <= '0;
        end else if (op == mshr_entry_pkg::OP_CHECK || op == mshr_entry_pkg::OP_ACK) begin
            for (int w = 0; w < mshr_cfg_pkg::MSHR_WAYS; w++) begin
                rentry_q[w] <= mem_q[addr][w];
            end
        end
    end

    assign rentry_o = rentry_q;

endmodule

// File: mshr/mshr_hit_check.sv
`timescale 1ns/1ps

module mshr_hit_check (
    input  logic                                                        clk_i,
    input  logic                                                        rst_ni,

    input  logic                                                        check_i,
    input  logic                                                        alloc_i,
    input  mshr_cfg_pkg::cache_set_t                                    check_set_i,
    input  mshr_cfg_pkg::tag_t                                          check_tag_i,

    input  logic [mshr_cfg_pkg::MSHR_SLOTS-1:0]                         valid_i,
    input  mshr_cfg_pkg::cache_set_t [mshr_cfg_pkg::MSHR_SLOTS-1:0]     cache_set_i,
    input  mshr_entry_pkg::mshr_entry_t [mshr_cfg_pkg::MSHR_WAYS-1:0]   rentry_i,

    output mshr_cfg_pkg::mshr_set_t                                     check_set_q_o,
    output logic                                                        hit_o
);

    mshr_cfg_pkg::cache_set_t check_cache_set_q;

    // Stage 0 to stage 1 unless an allocation takes the memory
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            check_cache_set_q <= '0;
        end else if (check_i && !alloc_i) begin
            check_cache_set_q <= check_set_i;
        end
    end

    assign check_set_q_o = check_cache_set_q[mshr_cfg_pkg::MSHR_SET_W-1:0];

    // Stage 1 compare against every way of the checked MSHR set
    always_comb begin
        int slot;
        logic match_set;
        logic match_tag;

        hit_o = 1'b0;
        for (int w = 0; w < mshr_cfg_pkg::MSHR_WAYS; w++) begin
            slot      = w * mshr_cfg_pkg::MSHR_SETS + int'(check_set_q_o);
            match_set = (cache_set_i[slot] == check_cache_set_q);
            match_tag = (rentry_i[w].tag == check_tag_i);
            if (valid_i[slot] && match_set && match_tag) begin
                hit_o = 1'b1;
            end
        end
    end

endmodule

// File: mshr/mshr_ack_read.sv
`timescale 1ns/1ps

module mshr_ack_read (
    input  logic                                                        clk_i,
    input  logic                                                        rst_ni,

    input  logic                                                        ack_i,
    input  mshr_cfg_pkg::mshr_set_t                                     ack_set_i,
    input  mshr_cfg_pkg::mshr_way_t                                     ack_way_i,

    input  mshr_cfg_pkg::cache_set_t [mshr_cfg_pkg::MSHR_SLOTS-1:0]     cache_set_i,
    input  mshr_entry_pkg::mshr_entry_t [mshr_cfg_pkg::MSHR_WAYS-1:0]   rentry_i,

    output logic [mshr_cfg_pkg::REQ_ID_W-1:0]                           ack_req_id_o,
    output logic [mshr_cfg_pkg::SRC_ID_W-1:0]                           ack_src_id_o,
    output mshr_cfg_pkg::cache_set_t                                    ack_cache_set_o,
    output logic [mshr_cfg_pkg::CACHE_WAY_W-1:0]                        ack_cache_way_o,
    output mshr_cfg_pkg::tag_t                                          ack_cache_tag_o,
    output logic [mshr_cfg_pkg::WORD_W-1:0]                             ack_word_o,
    output logic                                                        ack_need_rsp_o
);

    mshr_cfg_pkg::mshr_set_t ack_set_q;
    mshr_cfg_pkg::mshr_way_t ack_way_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ack_set_q <= '0;
            ack_way_q <= '0;
        end else if (ack_i) begin
            ack_set_q <= ack_set_i;
            ack_way_q <= ack_way_i;
        end
    end

    // Stored cache set stays readable after the slot is freed
    assign ack_cache_set_o = cache_set_i[{ack_way_q, ack_set_q}];

    // Memory read data of the acknowledged way
    assign ack_cache_tag_o = rentry_i[ack_way_q].tag;
    assign ack_req_id_o    = rentry_i[ack_way_q].req_id;
    assign ack_src_id_o    = rentry_i[ack_way_q].src_id;
    assign ack_word_o      = rentry_i[ack_way_q].word_idx;
    assign ack_cache_way_o = rentry_i[ack_way_q].victim_way;
    assign ack_need_rsp_o  = rentry_i[ack_way_q].need_rsp;

endmodule

// File: rtl/mshr_top.sv
`timescale 1ns/1ps

module mshr_top (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,

    // Check with the tag one cycle after the set
    input  logic                                    check_i,
    input  mshr_cfg_pkg::cache_set_t                check_set_i,
    input  mshr_cfg_pkg::tag_t                      check_tag_i,
    output logic                                    hit_o,

    // Allocate
    input  logic                                    alloc_i,
    input  mshr_cfg_pkg::nline_t                    alloc_nline_i,
    input  logic [mshr_cfg_pkg::REQ_ID_W-1:0]       alloc_req_id_i,
    input  logic [mshr_cfg_pkg::SRC_ID_W-1:0]       alloc_src_id_i,
    input  logic [mshr_cfg_pkg::WORD_W-1:0]         alloc_word_i,
    input  logic [mshr_cfg_pkg::CACHE_WAY_W-1:0]    alloc_victim_way_i,
    input  logic                                    alloc_need_rsp_i,
    output logic                                    alloc_full_o,
    output mshr_cfg_pkg::mshr_way_t                 alloc_way_o,

    // Acknowledge
    input  logic                                    ack_i,
    input  mshr_cfg_pkg::mshr_set_t                 ack_set_i,
    input  mshr_cfg_pkg::mshr_way_t                 ack_way_i,
    output logic [mshr_cfg_pkg::REQ_ID_W-1:0]       ack_req_id_o,
    output logic [mshr_cfg_pkg::SRC_ID_W-1:0]       ack_src_id_o,
    output mshr_cfg_pkg::cache_set_t                ack_cache_set_o,
    output logic [mshr_cfg_pkg::CACHE_WAY_W-1:0]    ack_cache_way_o,
    output mshr_cfg_pkg::tag_t                      ack_cache_tag_o,
    output logic [mshr_cfg_pkg::WORD_W-1:0]         ack_word_o,
    output logic                                    ack_need_rsp_o,

    // Status
    output logic                                    empty_o,
    output logic                                    full_o
);

    logic [mshr_cfg_pkg::MSHR_SLOTS-1:0]                        valid;
    mshr_cfg_pkg::cache_set_t [mshr_cfg_pkg::MSHR_SLOTS-1:0]    cache_set;
    mshr_entry_pkg::mshr_entry_t [mshr_cfg_pkg::MSHR_WAYS-1:0]  rentry;
    mshr_cfg_pkg::mshr_set_t                                    check_set_q;

    mshr_valid_table u_valid_table (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .alloc_i       (alloc_i),
        .alloc_nline_i (alloc_nline_i),
        .ack_i         (ack_i),
        .ack_set_i     (ack_set_i),
        .ack_way_i     (ack_way_i),
        .check_set_q_i (check_set_q),
        .alloc_way_o   (alloc_way_o),
        .alloc_full_o  (alloc_full_o),
        .empty_o       (empty_o),
        .full_o        (full_o),
        .valid_o       (valid),
        .cache_set_o   (cache_set)
    );

    mshr_entry_ram u_entry_ram (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .check_i            (check_i),
        .alloc_i            (alloc_i),
        .ack_i              (ack_i),
        .check_set_i        (check_set_i),
        .ack_set_i          (ack_set_i),
        .alloc_nline_i      (alloc_nline_i),
        .alloc_way_i        (alloc_way_o),
        .alloc_req_id_i     (alloc_req_id_i),
        .alloc_src_id_i     (alloc_src_id_i),
        .alloc_word_i       (alloc_word_i),
        .alloc_victim_way_i (alloc_victim_way_i),
        .alloc_need_rsp_i   (alloc_need_rsp_i),
        .rentry_o           (rentry)
    );

    mshr_hit_check u_hit_check (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .check_i       (check_i),
        .alloc_i       (alloc_i),
        .check_set_i   (check_set_i),
        .check_tag_i   (check_tag_i),
        .valid_i       (valid),
        .cache_set_i   (cache_set),
        .rentry_i      (rentry),
        .check_set_q_o (check_set_q),
        .hit_o         (hit_o)
    );

    mshr_ack_read u_ack_read (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .ack_i           (ack_i),
        .ack_set_i       (ack_set_i),
        .ack_way_i       (ack_way_i),
        .cache_set_i     (cache_set),
        .rentry_i        (rentry),
        .ack_req_id_o    (ack_req_id_o),
        .ack_src_id_o    (ack_src_id_o),
        .ack_cache_set_o (ack_cache_set_o),
        .ack_cache_way_o (ack_cache_way_o),
        .ack_cache_tag_o (ack_cache_tag_o),
        .ack_word_o      (ack_word_o),
        .ack_need_rsp_o  (ack_need_rsp_o)
    );

endmodule

// File: test/tb_mshr.sv
`timescale 1ns/1ps

module tb_mshr;

    localparam string GOLDEN_FILE = "test/mshr_golden.txt";

    logic                                   clk_i;
    logic                                   rst_ni;
    logic                                   check_i;
    mshr_cfg_pkg::cache_set_t               check_set_i;
    mshr_cfg_pkg::tag_t                     check_tag_i;
    logic                                   hit_o;
    logic                                   alloc_i;
    mshr_cfg_pkg::nline_t                   alloc_nline_i;
    logic [mshr_cfg_pkg::REQ_ID_W-1:0]      alloc_req_id_i;
    logic [mshr_cfg_pkg::SRC_ID_W-1:0]      alloc_src_id_i;
    logic [mshr_cfg_pkg::WORD_W-1:0]        alloc_word_i;
    logic [mshr_cfg_pkg::CACHE_WAY_W-1:0]   alloc_victim_way_i;
    logic                                   alloc_need_rsp_i;
    logic                                   alloc_full_o;
    mshr_cfg_pkg::mshr_way_t                alloc_way_o;
    logic                                   ack_i;
    mshr_cfg_pkg::mshr_set_t                ack_set_i;
    mshr_cfg_pkg::mshr_way_t                ack_way_i;
    logic [mshr_cfg_pkg::REQ_ID_W-1:0]      ack_req_id_o;
    logic [mshr_cfg_pkg::SRC_ID_W-1:0]      ack_src_id_o;
    mshr_cfg_pkg::cache_set_t               ack_cache_set_o;
    logic [mshr_cfg_pkg::CACHE_WAY_W-1:0]   ack_cache_way_o;
    mshr_cfg_pkg::tag_t                     ack_cache_tag_o;
    logic [mshr_cfg_pkg::WORD_W-1:0]        ack_word_o;
    logic                                   ack_need_rsp_o;
    logic                                   empty_o;
    logic                                   full_o;

    // Operands of the current golden line
    logic [31:0]        f [0:8];

    // Results owed in the next cycle
    logic               chk_pend;
    mshr_cfg_pkg::tag_t chk_tag;
    logic               chk_hit;
    logic               chk_full;
    logic               ack_pend;
    logic [31:0]        ack_exp [0:6];

    int unsigned        cycles = 0;
    int unsigned        limit = 0;

    mshr_top u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
            fail_run("Output does not match the golden file");
        end
    endtask

    task automatic drive_idle();
        check_i            = 1'b0;
        check_set_i        = '0;
        alloc_i            = 1'b0;
        alloc_nline_i      = '0;
        alloc_req_id_i     = '0;
        alloc_src_id_i     = '0;
        alloc_word_i       = '0;
        alloc_victim_way_i = '0;
        alloc_need_rsp_i   = 1'b0;
        ack_i              = 1'b0;
        ack_set_i          = '0;
        ack_way_i          = '0;
    endtask

    task automatic read_operands(input int fd, input logic [7:0] op);
        int code;
        code = 0;
        case (op)
            "C": code = $fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]) - 4;
            "T": code = $fscanf(fd, "%h %h", f[0], f[1]) - 2;
            "A": code = $fscanf(fd, "%h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6]) - 7;
            "K": code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]) - 9;
            "N": code = 0;
            default: fail_run($sformatf("Unknown operation '%s' in the golden file", op));
        endcase
        if (code != 0) begin
            fail_run($sformatf("Golden line for operation '%s' has missing operands", op));
        end
    endtask

    // Called right after the falling edge
    task automatic apply_line(input logic [7:0] op);
        drive_idle();
        // Tag of the check from the previous cycle
        check_tag_i = chk_pend ? chk_tag : '0;
        case (op)
            "C": begin
                check_i     = 1'b1;
                check_set_i = f[0][mshr_cfg_pkg::CACHE_SET_W-1:0];
            end
            "A": begin
                alloc_i            = 1'b1;
                alloc_nline_i      = f[0][mshr_cfg_pkg::NLINE_W-1:0];
                alloc_req_id_i     = f[1][mshr_cfg_pkg::REQ_ID_W-1:0];
                alloc_src_id_i     = f[2][mshr_cfg_pkg::SRC_ID_W-1:0];
                alloc_word_i       = f[3][mshr_cfg_pkg::WORD_W-1:0];
                alloc_victim_way_i = f[4][mshr_cfg_pkg::CACHE_WAY_W-1:0];
                alloc_need_rsp_i   = f[5][0];
            end
            "K": begin
                ack_i     = 1'b1;
                ack_set_i = f[0][mshr_cfg_pkg::MSHR_SET_W-1:0];
                ack_way_i = f[1][mshr_cfg_pkg::MSHR_WAY_W-1:0];
            end
            default: ;
        endcase
    endtask

    // Sample late in the cycle, then record what the next cycle owes
    task automatic check_cycle(input logic [7:0] op);
        #2;
        if (chk_pend) begin
            check_val("hit_o", 32'(hit_o), 32'(chk_hit));
            check_val("alloc_full_o", 32'(alloc_full_o), 32'(chk_full));
        end
        if (ack_pend) begin
            check_val("ack_req_id_o", 32'(ack_req_id_o), ack_exp[0]);
            check_val("ack_src_id_o", 32'(ack_src_id_o), ack_exp[1]);
            check_val("ack_cache_set_o", 32'(ack_cache_set_o), ack_exp[2]);
            check_val("ack_cache_way_o", 32'(ack_cache_way_o), ack_exp[3]);
            check_val("ack_cache_tag_o", 32'(ack_cache_tag_o), ack_exp[4]);
            check_val("ack_word_o", 32'(ack_word_o), ack_exp[5]);
            check_val("ack_need_rsp_o", 32'(ack_need_rsp_o), ack_exp[6]);
        end
        if (op == "A") begin
            check_val("alloc_way_o", 32'(alloc_way_o), f[6]);
        end
        if (op == "T") begin
            check_val("empty_o", 32'(empty_o), f[0]);
            check_val("full_o", 32'(full_o), f[1]);
        end
        chk_pend = (op == "C");
        chk_tag  = f[1][mshr_cfg_pkg::TAG_W-1:0];
        chk_hit  = f[2][0];
        chk_full = f[3][0];
        ack_pend = (op == "K");
        for (int i = 0; i < 7; i++) begin
            ack_exp[i] = f[i + 2];
        end
    endtask

    initial begin
        int fd;
        int code;
        int n_lines;
        logic [8*128-1:0] text;
        logic [7:0] op;
        logic done;

        rst_ni      = 1'b0;
        check_tag_i = '0;
        chk_pend    = 1'b0;
        ack_pend    = 1'b0;
        drive_idle();

        // Line count sets the cycle budget
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            fail_run("Cannot open the golden file test/mshr_golden.txt");
        end
        n_lines = 0;
        while ($fgets(text, fd) != 0) begin
            n_lines++;
        end
        $fclose(fd);
        limit = 4 * n_lines + 20;

        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            fail_run("Cannot reopen the golden file test/mshr_golden.txt");
        end

        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", op);
            if (code != 1) begin
                done = 1'b1;
            end else if (op == "#") begin
                code = $fgets(text, fd);
            end else begin
                read_operands(fd, op);
                @(negedge clk_i);
                apply_line(op);
                check_cycle(op);
            end
        end
        $fclose(fd);

        // Flush the last tag cycle or ack readout
        @(negedge clk_i);
        apply_line("N");
        check_cycle("N");

        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        wait (limit != 0);
        while (cycles < limit) begin
            @(posedge clk_i);
            cycles++;
        end
        fail_run($sformatf("Timeout: test did not finish within %0d clock cycles", cycles));
    end

endmodule

// File: test/mshr_golden.txt
# C: cache_set tag hit alloc_full (tag and results next cycle)  T: empty full  N: idle
# A: nline req src word victim need_rsp way (way same cycle)  K: set way req src cset cway tag word need_rsp
T 1 0
C 05 3a 0 0
A e85 7 2 5 3 1 0
C 05 3a 1 0
C 05 3b 0 0
C 09 3a 0 0
A 170d a 1 2 0 0 1
C 0d 5c 1 1
C 02 11 0 0
K 1 0 7 2 05 3 3a 5 1
C 05 3a 0 0
A 855 3 0 7 1 1 0
K 1 0 3 0 15 1 21 7 1
K 1 1 a 1 0d 0 5c 2 0
T 1 0
N
A 040 0 0 0 0 0 0
A 081 1 1 1 1 1 0
A 0c2 2 2 2 2 0 0
A 103 3 3 3 3 1 0
A 144 4 0 4 0 1 1
A 185 5 1 5 1 0 1
A 1c6 6 2 6 2 1 1
A 207 8 3 7 3 0 1
T 0 1
C 26 07 0 1
C 06 07 1 1
K 0 0 0 0 00 0 01 0 0
K 1 0 1 1 01 1 02 1 1
K 2 0 2 2 02 2 03 2 0
K 3 0 3 3 03 3 04 3 1
K 0 1 4 0 04 0 05 4 1
K 1 1 5 1 05 1 06 5 0
K 2 1 6 2 06 2 07 6 1
T 0 0
K 3 1 8 3 07 3 08 7 0
T 1 0

// File: all.f
common/mshr_cfg_pkg.sv
common/mshr_entry_pkg.sv
mshr/mshr_valid_table.sv
mshr/mshr_entry_ram.sv
mshr/mshr_hit_check.sv
mshr/mshr_ack_read.sv
rtl/mshr_top.sv
test/tb_mshr.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the MSHR testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f all.f --top-module tb_mshr -o tb_mshr_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_mshr_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
